// ==== include/sifh_config.svh ====
`ifndef SIFH_CONFIG_SVH
`define SIFH_CONFIG_SVH

// tdc bin code width, one histogram per pixel
`define HIST_BIN_W 4

// bins in one pixel histogram
`define HIST_BIN_NUM 16

// bin count width
// counts stop at the all-ones value
`define HIST_COUNT_W 3

// pixels held in one bank
`define HIST_PIXEL_NUM 4

// hits taken for a pixel before stepping to the next one
`define HIST_DATA_NUM 4

// acquisitions in one frame
// frame length is data * pixel * acq hits
`define HIST_ACQ_NUM 3

// bank address width
// address is pixel * HIST_BIN_NUM + bin
`define HIST_ADDR_W 6

`endif

// ==== source/sifh_hist_pkg.sv ====
`default_nettype none

`include "sifh_config.svh"

package sifh_hist_pkg;

    // photon arrival bin from the tdc
    typedef logic [`HIST_BIN_W-1:0] hist_bin_t;

    // entry address inside one bank
    typedef logic [`HIST_ADDR_W-1:0] hist_addr_t;

    // one saturating bin count
    typedef logic [`HIST_COUNT_W-1:0] hist_count_t;

    // bank select, two banks ping-pong between builder and readout
    typedef logic bank_sel_t;

    // builder fsm
    typedef enum logic [1:0] {
        BUILD_IDLE  = 2'd0,
        BUILD_READ  = 2'd1,
        BUILD_WRITE = 2'd2,
        BUILD_STALL = 2'd3
    } build_state_e;

endpackage

`default_nettype wire

// ==== source/sifh_link_pkg.sv ====
`default_nettype none

package sifh_link_pkg;

    // four-phase req/ack link states
    // idle: no transfer on the link
    // wait_ack: req high, waiting for the other side to ack
    // wait_release: ack seen, waiting for the handshake to return to zero
    typedef enum logic [1:0] {
        LINK_IDLE         = 2'd0,
        LINK_WAIT_ACK     = 2'd1,
        LINK_WAIT_RELEASE = 2'd2
    } link_state_e;

endpackage

`default_nettype wire

// ==== source/hist_event_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module hist_event_capture
    import sifh_hist_pkg::*, sifh_link_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      combin_res,
    // tdc side
    input  wire logic      evt_req,
    input  wire hist_bin_t evt_bin,
    output logic           evt_ack,
    // builder side
    input  wire logic      hit_ready,
    output logic           hit_valid,
    output hist_bin_t      hit_bin
);

    link_state_e state;
    logic        take_hit;

    // new hit only when the link is idle and the builder can accept it
    assign take_hit = (state == LINK_IDLE) && evt_req && hit_ready;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state     <= LINK_IDLE;
            evt_ack   <= 1'b0;
            hit_valid <= 1'b0;
        end else begin
            // strobe lasts one cycle
            hit_valid <= 1'b0;
            case (state)
                LINK_IDLE: begin
                    if (take_hit) begin
                        hit_valid <= 1'b1;
                        evt_ack   <= 1'b1;
                        state     <= LINK_WAIT_RELEASE;
                    end
                end
                LINK_WAIT_RELEASE: begin
                    // tdc dropped req, finish the return to zero
                    if (!evt_req) begin
                        evt_ack <= 1'b0;
                        state   <= LINK_IDLE;
                    end
                end
                default: state <= LINK_IDLE;
            endcase
        end
    end

    // bin is stable while req is high, grab it with the strobe
    always_ff @(posedge clk) begin
        if (take_hit) begin
            hit_bin <= evt_bin;
        end
    end

endmodule

`default_nettype wire

// ==== source/hist_builder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sifh_config.svh"

module hist_builder
    import sifh_hist_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        combin_res,
    // from capture
    input  wire logic        hit_valid,
    input  wire hist_bin_t   hit_bin,
    output logic             hit_ready,
    // count memory port
    output bank_sel_t        bld_bank,
    output hist_addr_t       bld_addr,
    output logic             bld_wr,
    output hist_count_t      bld_wdata,
    input  wire hist_count_t bld_rdata,
    // readout handoff
    input  wire logic        rd_busy,
    output logic             frame_done,
    output bank_sel_t        frame_bank,
    // active bank
    output bank_sel_t        hist_bank
);

    localparam int DATA_W = $clog2(`HIST_DATA_NUM);
    localparam int PIX_W  = $clog2(`HIST_PIXEL_NUM);
    localparam int ACQ_W  = $clog2(`HIST_ACQ_NUM);

    localparam logic [DATA_W-1:0] DATA_LAST  = DATA_W'(`HIST_DATA_NUM - 1);
    localparam logic [PIX_W-1:0]  PIXEL_LAST = PIX_W'(`HIST_PIXEL_NUM - 1);
    localparam logic [ACQ_W-1:0]  ACQ_LAST   = ACQ_W'(`HIST_ACQ_NUM - 1);

    localparam hist_count_t COUNT_MAX = '1;

    build_state_e      state;
    // nested counters: hits per pixel, pixels, acquisitions
    logic [DATA_W-1:0] data_cnt;
    logic [PIX_W-1:0]  pixel_cnt;
    logic [ACQ_W-1:0]  acq_cnt;
    logic              frame_end;

    // last hit of the last pixel of the last acquisition
    assign frame_end = (data_cnt == DATA_LAST) && (pixel_cnt == PIXEL_LAST) &&
                       (acq_cnt == ACQ_LAST);

    assign hit_ready = (state == BUILD_IDLE);
    assign bld_bank  = hist_bank;
    assign bld_wr    = (state == BUILD_WRITE);

    // saturating increment of the count read back
    assign bld_wdata = (bld_rdata == COUNT_MAX) ? bld_rdata : bld_rdata + 1'b1;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state      <= BUILD_IDLE;
            data_cnt   <= '0;
            pixel_cnt  <= '0;
            acq_cnt    <= '0;
            bld_addr   <= '0;
            hist_bank  <= 1'b0;
            frame_bank <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (state)
                BUILD_IDLE: begin
                    // entry for this pixel's histogram bin
                    if (hit_valid) begin
                        bld_addr <= hist_addr_t'(pixel_cnt * `HIST_BIN_NUM + hit_bin);
                        state    <= BUILD_READ;
                    end
                end
                BUILD_READ: begin
                    // memory returns the count next cycle
                    state <= BUILD_WRITE;
                end
                BUILD_WRITE: begin
                    // count is written this cycle, step the counters
                    if (data_cnt == DATA_LAST) begin
                        data_cnt <= '0;
                        if (pixel_cnt == PIXEL_LAST) begin
                            pixel_cnt <= '0;
                            if (acq_cnt == ACQ_LAST) begin
                                acq_cnt <= '0;
                            end else begin
                                acq_cnt <= acq_cnt + 1'b1;
                            end
                        end else begin
                            pixel_cnt <= pixel_cnt + 1'b1;
                        end
                    end else begin
                        data_cnt <= data_cnt + 1'b1;
                    end

                    if (!frame_end) begin
                        state <= BUILD_IDLE;
                    end else if (rd_busy) begin
                        // other bank still draining, hold the frame
                        state <= BUILD_STALL;
                    end else begin
                        frame_done <= 1'b1;
                        frame_bank <= hist_bank;
                        hist_bank  <= ~hist_bank;
                        state      <= BUILD_IDLE;
                    end
                end
                BUILD_STALL: begin
                    // readout done, hand over the waiting bank
                    if (!rd_busy) begin
                        frame_done <= 1'b1;
                        frame_bank <= hist_bank;
                        hist_bank  <= ~hist_bank;
                        state      <= BUILD_IDLE;
                    end
                end
                default: state <= BUILD_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/hist_bank_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sifh_config.svh"

module hist_bank_ram
    import sifh_hist_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        combin_res,
    // builder port, read and write
    input  wire bank_sel_t   bld_bank,
    input  wire hist_addr_t  bld_addr,
    input  wire logic        bld_wr,
    input  wire hist_count_t bld_wdata,
    output hist_count_t      bld_rdata,
    // readout port, read with clear
    input  wire bank_sel_t   rd_bank,
    input  wire hist_addr_t  rd_addr,
    input  wire logic        rd_en,
    output hist_count_t      rd_data
);

    localparam int DEPTH = 1 << `HIST_ADDR_W;

    // count storage, both banks
    hist_count_t      mem [2][DEPTH];
    // per-entry valid, clear means the entry counts as zero
    logic [DEPTH-1:0] valid [2];

    always_ff @(posedge clk) begin
        if (bld_wr) begin
            mem[bld_bank][bld_addr] <= bld_wdata;
        end

        // builder read, one cycle latency
        bld_rdata <= valid[bld_bank][bld_addr] ? mem[bld_bank][bld_addr] : '0;

        // readout read holds its word until the next rd_en
        if (rd_en) begin
            rd_data <= valid[rd_bank][rd_addr] ? mem[rd_bank][rd_addr] : '0;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int b = 0; b < 2; b++) begin
                valid[b] <= '0;
            end
        end else begin
            // entry empties as it is read out
            if (rd_en) begin
                valid[rd_bank][rd_addr] <= 1'b0;
            end
            // builder always writes the other bank than the readout
            if (bld_wr) begin
                valid[bld_bank][bld_addr] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/hist_readout.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sifh_config.svh"

module hist_readout
    import sifh_hist_pkg::*, sifh_link_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        combin_res,
    // from builder
    input  wire logic        frame_done,
    input  wire bank_sel_t   frame_bank,
    output logic             rd_busy,
    // memory readout port
    output bank_sel_t        rd_bank,
    output hist_addr_t       rd_addr,
    output logic             rd_en,
    input  wire hist_count_t rd_data,
    // host link
    output logic             out_req,
    output hist_addr_t       out_addr,
    output hist_count_t      out_data,
    output logic             out_last,
    input  wire logic        out_ack
);

    // last entry of a bank
    localparam hist_addr_t LAST_ADDR = hist_addr_t'(`HIST_PIXEL_NUM * `HIST_BIN_NUM - 1);

    link_state_e state;

    // word on the link is the entry just fetched
    assign out_addr = rd_addr;
    assign out_data = rd_data;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state    <= LINK_IDLE;
            rd_busy  <= 1'b0;
            rd_bank  <= 1'b0;
            rd_addr  <= '0;
            rd_en    <= 1'b0;
            out_req  <= 1'b0;
            out_last <= 1'b0;
        end else begin
            // fetch is a single cycle
            rd_en <= 1'b0;
            case (state)
                LINK_IDLE: begin
                    if (rd_en) begin
                        // data lands with req
                        out_req  <= 1'b1;
                        out_last <= (rd_addr == LAST_ADDR);
                        state    <= LINK_WAIT_ACK;
                    end else if (frame_done && !rd_busy) begin
                        // start the dump at entry 0
                        rd_busy <= 1'b1;
                        rd_bank <= frame_bank;
                        rd_addr <= '0;
                        rd_en   <= 1'b1;
                    end
                end
                LINK_WAIT_ACK: begin
                    // slow host keeps us here
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= LINK_WAIT_RELEASE;
                    end
                end
                LINK_WAIT_RELEASE: begin
                    if (!out_ack) begin
                        out_last <= 1'b0;
                        state    <= LINK_IDLE;
                        if (rd_addr == LAST_ADDR) begin
                            // bank drained and cleared
                            rd_busy <= 1'b0;
                        end else begin
                            rd_addr <= rd_addr + 1'b1;
                            rd_en   <= 1'b1;
                        end
                    end
                end
                default: state <= LINK_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/sifh_histogram_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifh_histogram_top
    import sifh_hist_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      combin_res,
    // tdc link
    input  wire logic      evt_req,
    input  wire hist_bin_t evt_bin,
    output logic           evt_ack,
    // host link
    output logic           out_req,
    output hist_addr_t     out_addr,
    output hist_count_t    out_data,
    output logic           out_last,
    input  wire logic      out_ack,
    // bank being filled
    output bank_sel_t      hist_bank
);

    // capture to builder
    logic        hit_ready;
    logic        hit_valid;
    hist_bin_t   hit_bin;
    // builder to memory
    bank_sel_t   bld_bank;
    hist_addr_t  bld_addr;
    logic        bld_wr;
    hist_count_t bld_wdata;
    hist_count_t bld_rdata;
    // builder to readout
    logic        rd_busy;
    logic        frame_done;
    bank_sel_t   frame_bank;
    // readout to memory
    bank_sel_t   rd_bank;
    hist_addr_t  rd_addr;
    logic        rd_en;
    hist_count_t rd_data;

    hist_event_capture u_hist_event_capture (
        .clk        (clk),
        .combin_res (combin_res),
        .evt_req    (evt_req),
        .evt_bin    (evt_bin),
        .evt_ack    (evt_ack),
        .hit_ready  (hit_ready),
        .hit_valid  (hit_valid),
        .hit_bin    (hit_bin)
    );

    hist_builder u_hist_builder (
        .clk        (clk),
        .combin_res (combin_res),
        .hit_valid  (hit_valid),
        .hit_bin    (hit_bin),
        .hit_ready  (hit_ready),
        .bld_bank   (bld_bank),
        .bld_addr   (bld_addr),
        .bld_wr     (bld_wr),
        .bld_wdata  (bld_wdata),
        .bld_rdata  (bld_rdata),
        .rd_busy    (rd_busy),
        .frame_done (frame_done),
        .frame_bank (frame_bank),
        .hist_bank  (hist_bank)
    );

    hist_bank_ram u_hist_bank_ram (
        .clk        (clk),
        .combin_res (combin_res),
        .bld_bank   (bld_bank),
        .bld_addr   (bld_addr),
        .bld_wr     (bld_wr),
        .bld_wdata  (bld_wdata),
        .bld_rdata  (bld_rdata),
        .rd_bank    (rd_bank),
        .rd_addr    (rd_addr),
        .rd_en      (rd_en),
        .rd_data    (rd_data)
    );

    hist_readout u_hist_readout (
        .clk        (clk),
        .combin_res (combin_res),
        .frame_done (frame_done),
        .frame_bank (frame_bank),
        .rd_busy    (rd_busy),
        .rd_bank    (rd_bank),
        .rd_addr    (rd_addr),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .out_req    (out_req),
        .out_addr   (out_addr),
        .out_data   (out_data),
        .out_last   (out_last),
        .out_ack    (out_ack)
    );

endmodule

`default_nettype wire

// ==== dv/sifh_histogram_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sifh_config.svh"

module sifh_histogram_tb
    import sifh_hist_pkg::*;
();

    localparam int BIN_NUM      = `HIST_BIN_NUM;
    localparam int BANK_WORDS   = `HIST_PIXEL_NUM * `HIST_BIN_NUM;
    localparam int FRAME_EVENTS = `HIST_DATA_NUM * `HIST_PIXEL_NUM * `HIST_ACQ_NUM;
    localparam int COUNT_MAX    = (1 << `HIST_COUNT_W) - 1;
    localparam int WAIT_LIMIT   = 500;
    localparam int DUMP_LIMIT   = 20000;

    logic        clk;
    logic        combin_res;
    logic        evt_req;
    hist_bin_t   evt_bin;
    logic        evt_ack;
    logic        out_req;
    hist_addr_t  out_addr;
    hist_count_t out_data;
    logic        out_last;
    logic        out_ack;
    bank_sel_t   hist_bank;

    int   errors;
    int   frames_done;
    // expected counts, two slots so two frames can be in flight
    int   ref_hist [2][BANK_WORDS];
    // words seen in the latest dump
    int   dump_data [BANK_WORDS];
    logic dump_done;

    sifh_histogram_top u_sifh_histogram_top (
        .clk        (clk),
        .combin_res (combin_res),
        .evt_req    (evt_req),
        .evt_bin    (evt_bin),
        .evt_ack    (evt_ack),
        .out_req    (out_req),
        .out_addr   (out_addr),
        .out_data   (out_data),
        .out_last   (out_last),
        .out_ack    (out_ack),
        .hist_bank  (hist_bank)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic timeout_error(input string what);
        $display("Timeout at %0t: %s", $time, what);
        errors++;
    endtask

    // tdc puts the bin up and raises req
    task automatic drive_event(input hist_bin_t bin);
        @(posedge clk);
        evt_bin <= bin;
        evt_req <= 1'b1;
    endtask

    // rest of the four-phase cycle on the tdc side
    task automatic complete_event();
        int n;
        n = 0;
        @(posedge clk);
        while (!evt_ack && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!evt_ack) begin
            timeout_error("evt_ack never rose for a TDC event");
        end
        evt_req <= 1'b0;
        n = 0;
        @(posedge clk);
        while (evt_ack && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (evt_ack) begin
            timeout_error("evt_ack never dropped after evt_req fell");
        end
    endtask

    task automatic send_event(input hist_bin_t bin);
        drive_event(bin);
        complete_event();
    endtask

    // whole frame, pixel sat_pixel forced to sat_bin, -1 means all random
    task automatic send_frame(input int slot, input int sat_pixel, input int sat_bin);
        int        pixel;
        int        addr;
        hist_bin_t bin;
        for (int a = 0; a < BANK_WORDS; a++) begin
            ref_hist[slot][a] = 0;
        end
        for (int k = 0; k < FRAME_EVENTS; k++) begin
            // hits per pixel first, then pixels, acquisitions wrap the pixel index
            pixel = (k / `HIST_DATA_NUM) % `HIST_PIXEL_NUM;
            if (pixel == sat_pixel) begin
                bin = hist_bin_t'(sat_bin);
            end else begin
                bin = hist_bin_t'($urandom % BIN_NUM);
            end
            addr = pixel * BIN_NUM + int'(bin);
            if (ref_hist[slot][addr] < COUNT_MAX) begin
                ref_hist[slot][addr]++;
            end
            send_event(bin);
        end
        frames_done++;
    endtask

    // host side, ack_delay cycles of back-pressure per word
    task automatic read_frame(input int slot, input int ack_delay);
        int n;
        for (int a = 0; a < BANK_WORDS; a++) begin
            n = 0;
            @(posedge clk);
            while (!out_req && n < WAIT_LIMIT) begin
                @(posedge clk);
                n++;
            end
            if (!out_req) begin
                timeout_error("out_req never rose for a dump word");
            end
            check_value("out_addr", out_addr, a);
            check_value("out_data", out_data, ref_hist[slot][a]);
            check_value("out_last", out_last, a == BANK_WORDS - 1);
            dump_data[a] = out_data;
            repeat (ack_delay) @(posedge clk);
            out_ack <= 1'b1;
            n = 0;
            @(posedge clk);
            while (out_req && n < WAIT_LIMIT) begin
                @(posedge clk);
                n++;
            end
            if (out_req) begin
                timeout_error("out_req never dropped after out_ack");
            end
            out_ack <= 1'b0;
        end
        dump_done = 1'b1;
    endtask

    // no evt_ack allowed until the running dump has finished
    task automatic watch_no_ack();
        int n;
        n = 0;
        while (!dump_done && n < DUMP_LIMIT) begin
            @(posedge clk);
            check_value("evt_ack", evt_ack, 0);
            n++;
        end
        if (!dump_done) begin
            timeout_error("held dump never finished");
        end
    endtask

    task automatic test_reset_idle();
        check_value("evt_ack", evt_ack, 0);
        check_value("out_req", out_req, 0);
        check_value("out_last", out_last, 0);
        check_value("hist_bank", hist_bank, 0);
        // nothing to dump yet
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            check_value("out_req", out_req, 0);
        end
    endtask

    task automatic test_frame(input int sat_pixel, input int sat_bin);
        send_frame(0, sat_pixel, sat_bin);
        read_frame(0, 0);
        check_value("hist_bank", hist_bank, frames_done % 2);
    endtask

    task automatic test_backpressure();
        // frame a, its dump waits on the host
        send_frame(0, -1, 0);
        // frame b fills the other bank, then the builder stalls
        send_frame(1, -1, 0);
        drive_event(hist_bin_t'($urandom % BIN_NUM));
        dump_done = 1'b0;
        fork
            read_frame(0, 3);
            watch_no_ack();
        join
        // stall released, frame b handed over
        complete_event();
        check_value("hist_bank", hist_bank, frames_done % 2);
        read_frame(1, 2);
        check_value("hist_bank", hist_bank, frames_done % 2);
    endtask

    initial begin
        void'($urandom(32'h3348e796));
        clk         = 1'b0;
        combin_res  = 1'b0;
        evt_req     = 1'b0;
        evt_bin     = '0;
        out_ack     = 1'b0;
        errors      = 0;
        frames_done = 0;
        dump_done   = 1'b0;
        repeat (2) @(posedge clk);
        combin_res <= 1'b1;
        @(posedge clk);

        test_reset_idle();
        // random frame into bank 0, then bank 1
        test_frame(-1, 0);
        test_frame(-1, 0);
        // bank 0 again, pixel 2 piles into bin 5
        test_frame(2, 5);
        check_value("saturated bin", dump_data[2 * BIN_NUM + 5], COUNT_MAX);
        test_backpressure();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sifh_histogram.f ====
+incdir+include
source/sifh_hist_pkg.sv
source/sifh_link_pkg.sv
source/hist_event_capture.sv
source/hist_builder.sv
source/hist_bank_ram.sv
source/hist_readout.sv
source/sifh_histogram_top.sv
dv/sifh_histogram_tb.sv
